//--- design/cpu_cfg.svh
/* CPU configuration
   Word sizes, memory depth and the APB register map of the pipelined CPU */

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_DATA_WIDTH      8
`define CPU_ADDR_WIDTH      8
`define CPU_MEM_DEPTH       256
`define CPU_REG_COUNT       4
`define CPU_COUNT_WIDTH     16

// APB side of the host port
`define CPU_APB_ADDR_WIDTH  12
`define CPU_APB_DATA_WIDTH  32
`define CPU_ADDR_CTRL       12'h000
`define CPU_ADDR_STATUS     12'h004
`define CPU_ADDR_CYCLES     12'h008
`define CPU_ADDR_RETIRED    12'h00C
`define CPU_ADDR_REG_BASE   12'h010
`define CPU_ADDR_REG_MASK   12'hFF3
`define CPU_ADDR_MEM_BASE   12'h100
`define CPU_ADDR_MEM_MASK   12'hF00

`endif

//--- design/cpuPkg.sv
/* CPU package
   Instruction opcodes, ALU operations, APB slave states and the
   register file type shared by the core, the host port and the status bus */

`default_nettype none
`include "cpu_cfg.svh"

package cpuPkg;

  // Four-bit opcode in the low nibble of every instruction
  // ORI also decodes from 1111, since only the low three bits identify it
  typedef enum logic [3:0] {
    OP_LOAD  = 4'b0000,
    OP_STOP  = 4'b0001,
    OP_STORE = 4'b0010,
    OP_ADD   = 4'b0100,
    OP_BZ    = 4'b0101,
    OP_SUB   = 4'b0110,
    OP_ORI   = 4'b0111,
    OP_NAND  = 4'b1000,
    OP_BNZ   = 4'b1001,
    OP_NOP   = 4'b1010,
    OP_BPZ   = 4'b1101
  } opcodeE;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_NAND,
    ALU_OR,
    ALU_PASS
  } aluOpE;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_ACCESS,
    APB_WAIT
  } apbStateE;

  // R0 is element 0
  typedef logic [`CPU_REG_COUNT-1:0][`CPU_DATA_WIDTH-1:0] regFileT;

endpackage

`default_nettype wire

//--- design/memBusIf.sv
/* Memory bus
   Instruction, data and host ports of the unified memory, with one
   modport per side: the core, the host port and the memory itself */

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

interface memBusIf;
  // The instruction port returns read data one cycle after the address
  logic [`CPU_ADDR_WIDTH-1:0] instrAddr;
  logic [`CPU_DATA_WIDTH-1:0] instr;

  // The data port reads combinationally so execute sees the data in the same cycle
  logic [`CPU_ADDR_WIDTH-1:0] dataAddr;
  logic [`CPU_DATA_WIDTH-1:0] dataWdata;
  logic                       dataWe;
  logic [`CPU_DATA_WIDTH-1:0] dataRdata;

  // The host port has a registered read like the instruction port
  logic [`CPU_ADDR_WIDTH-1:0] hostAddr;
  logic [`CPU_DATA_WIDTH-1:0] hostWdata;
  logic                       hostWe;
  logic [`CPU_DATA_WIDTH-1:0] hostRdata;

  modport core (output instrAddr, dataAddr, dataWdata, dataWe, input instr, dataRdata);
  modport host (output hostAddr, hostWdata, hostWe, input hostRdata);
  modport mem (
    input  instrAddr, dataAddr, dataWdata, dataWe, hostAddr, hostWdata, hostWe,
    output instr, dataRdata, hostRdata
  );
endinterface

`default_nettype wire

//--- design/coreStatusIf.sv
/* Core status bus
   Start request from the host and run state, retire pulses and
   register values from the core */

`timescale 1ns/10ps
`default_nettype none

interface coreStatusIf;
  logic            start;
  logic            running;
  logic            halted;
  // One pulse per instruction leaving writeback
  logic            retire;
  cpuPkg::regFileT regs;

  modport core (input start, output running, halted, retire, regs);
  modport host (output start, input running, halted, regs);
  modport monitor (input start, running, retire);
endinterface

`default_nettype wire

//--- design/apbHostPort.sv
/* APB host port
   Decodes the control, status, counter, register and memory windows,
   adds one wait state to memory reads and starts the core on a CTRL write */

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module apbHostPort (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [`CPU_APB_ADDR_WIDTH-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [`CPU_APB_DATA_WIDTH-1:0] pwdata,
  output logic [`CPU_APB_DATA_WIDTH-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  memBusIf.host                          mem,
  coreStatusIf.host                      status,
  input  logic [`CPU_COUNT_WIDTH-1:0]    cycles,
  input  logic [`CPU_COUNT_WIDTH-1:0]    retired
);
  cpuPkg::apbStateE state;
  logic isCtrl;
  logic isStatus;
  logic isCycles;
  logic isRetired;
  logic isReg;
  logic isMem;
  logic refused;
  logic memRead;
  logic accessPhase;
  logic startPulse;

  assign isCtrl    = paddr == `CPU_ADDR_CTRL;
  assign isStatus  = paddr == `CPU_ADDR_STATUS;
  assign isCycles  = paddr == `CPU_ADDR_CYCLES;
  assign isRetired = paddr == `CPU_ADDR_RETIRED;
  assign isReg     = (paddr & `CPU_ADDR_REG_MASK) == `CPU_ADDR_REG_BASE;
  assign isMem     = (paddr & `CPU_ADDR_MEM_MASK) == `CPU_ADDR_MEM_BASE;

  // Memory and CTRL writes are locked out while a program runs
  assign refused     = pwrite && (isCtrl || isMem) && status.running;
  assign memRead     = !pwrite && isMem;
  assign accessPhase = (state == cpuPkg::APB_ACCESS) && psel && penable;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= cpuPkg::APB_IDLE;
      startPulse <= 1'b0;
    end else begin
      startPulse <= accessPhase && pwrite && isCtrl && pwdata[0] && !status.running;
      case (state)
        cpuPkg::APB_IDLE: begin
          if (psel && !penable) begin
            state <= cpuPkg::APB_ACCESS;
          end
        end
        cpuPkg::APB_ACCESS: begin
          if (!psel) begin
            state <= cpuPkg::APB_IDLE;
          end else if (penable) begin
            state <= memRead ? cpuPkg::APB_WAIT : cpuPkg::APB_IDLE;
          end
        end
        default: state <= cpuPkg::APB_IDLE;
      endcase
    end
  end

  // The memory latches its read data during the first access cycle
  assign pready  = (accessPhase && !memRead) || (state == cpuPkg::APB_WAIT);
  assign pslverr = pready && (refused || !(isCtrl || isStatus || isCycles || isRetired ||
                                           isReg || isMem));

  always_comb begin
    prdata = '0;
    if (state == cpuPkg::APB_WAIT) begin
      prdata[`CPU_DATA_WIDTH-1:0] = mem.hostRdata;
    end else if (isStatus) begin
      prdata[1:0] = {status.running, status.halted};
    end else if (isCycles) begin
      prdata[`CPU_COUNT_WIDTH-1:0] = cycles;
    end else if (isRetired) begin
      prdata[`CPU_COUNT_WIDTH-1:0] = retired;
    end else if (isReg) begin
      prdata[`CPU_DATA_WIDTH-1:0] = status.regs[paddr[3:2]];
    end
  end

  assign mem.hostAddr  = paddr[`CPU_ADDR_WIDTH-1:0];
  assign mem.hostWdata = pwdata[`CPU_DATA_WIDTH-1:0];
  assign mem.hostWe    = accessPhase && pwrite && isMem && !status.running;
  assign status.start  = startPulse;

  assert property (@(posedge clock) disable iff (reset) pready |-> psel && penable)
    else $error("pready raised outside an APB access phase");

  // The core only raises running in the cycle after start
  assert property (@(posedge clock) disable iff (reset) status.start |-> !status.running)
    else $error("start pulsed while the core was running");

endmodule

`default_nettype wire

//--- design/unifiedMemory.sv
/* Unified memory
   256 bytes shared by instructions and data, with a registered
   instruction read, a combinational data read and a host port */

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module unifiedMemory (
  input logic  clock,
  memBusIf.mem bus
);
  logic [`CPU_DATA_WIDTH-1:0] bytes [`CPU_MEM_DEPTH];

  always_ff @(posedge clock) begin
    bus.instr     <= bytes[bus.instrAddr];
    bus.hostRdata <= bytes[bus.hostAddr];
    if (bus.dataWe) begin
      bytes[bus.dataAddr] <= bus.dataWdata;
    end
    if (bus.hostWe) begin
      bytes[bus.hostAddr] <= bus.hostWdata;
    end
  end

  // Execute reads load data in the same cycle it presents the address
  assign bus.dataRdata = bytes[bus.dataAddr];

  // Host writes are only accepted while the core is stopped
  assert property (@(posedge clock) !(bus.dataWe && bus.hostWe))
    else $error("core and host wrote memory in the same cycle");

endmodule

`default_nettype wire

//--- design/pipelineCore.sv
/* Pipeline core
   Fetch, read, execute and writeback stages with a four-entry register
   file, N and Z flags, writeback forwarding and a two-stage branch flush */

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module pipelineCore (
  input  logic      clock,
  input  logic      reset,
  memBusIf.core     mem,
  coreStatusIf.core status
);
  logic [`CPU_ADDR_WIDTH-1:0] pc;
  logic [`CPU_ADDR_WIDTH-1:0] fetchAddr;
  logic [`CPU_ADDR_WIDTH-1:0] fetchPc;
  logic [`CPU_ADDR_WIDTH-1:0] readPc;
  logic [`CPU_ADDR_WIDTH-1:0] execPc;
  logic [`CPU_DATA_WIDTH-1:0] readInstr;
  logic [`CPU_DATA_WIDTH-1:0] execInstr;
  logic [`CPU_DATA_WIDTH-1:0] wbInstr;
  logic [`CPU_DATA_WIDTH-1:0] opA;
  logic [`CPU_DATA_WIDTH-1:0] opB;
  logic [`CPU_DATA_WIDTH-1:0] opAFwd;
  logic [`CPU_DATA_WIDTH-1:0] opBFwd;
  logic [`CPU_DATA_WIDTH-1:0] aluB;
  logic [`CPU_DATA_WIDTH-1:0] aluOut;
  logic [`CPU_DATA_WIDTH-1:0] wbData;
  logic [1:0]                 wbDest;
  cpuPkg::aluOpE              aluOp;
  cpuPkg::regFileT            regs;
  logic fetchValid;
  logic readValid;
  logic execValid;
  logic wbValid;
  logic wbWrite;
  logic execLive;
  logic halting;
  logic taken;
  logic flagWe;
  logic storeOp;
  logic branchCond;
  logic nFlag;
  logic zFlag;
  logic running;
  logic halted;

  function automatic logic isOri(input logic [`CPU_DATA_WIDTH-1:0] instr);
    return instr[2:0] == 3'b111;
  endfunction

  // ORI has no register field and always targets R1
  function automatic logic [1:0] regA(input logic [`CPU_DATA_WIDTH-1:0] instr);
    return isOri(instr) ? 2'd1 : instr[7:6];
  endfunction

  function automatic logic writesReg(input logic [`CPU_DATA_WIDTH-1:0] instr);
    if (isOri(instr)) begin
      return 1'b1;
    end
    case (cpuPkg::opcodeE'(instr[3:0]))
      cpuPkg::OP_LOAD, cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_NAND: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign halting  = wbValid && (cpuPkg::opcodeE'(wbInstr[3:0]) == cpuPkg::OP_STOP);
  // Anything younger than a STOP in writeback is discarded
  assign execLive = execValid && !halting;
  assign wbWrite  = wbValid && writesReg(wbInstr);
  assign wbDest   = regA(wbInstr);
  assign opAFwd   = (wbWrite && wbDest == regA(execInstr)) ? wbData : opA;
  assign opBFwd   = (wbWrite && wbDest == execInstr[5:4]) ? wbData : opB;

  always_comb begin
    aluOp      = cpuPkg::ALU_PASS;
    aluB       = opBFwd;
    flagWe     = 1'b0;
    storeOp    = 1'b0;
    branchCond = 1'b0;
    if (isOri(execInstr)) begin
      aluOp  = cpuPkg::ALU_OR;
      aluB   = {3'b000, execInstr[7:3]};
      flagWe = 1'b1;
    end else begin
      case (cpuPkg::opcodeE'(execInstr[3:0]))
        cpuPkg::OP_LOAD:  aluB = mem.dataRdata;
        cpuPkg::OP_STORE: storeOp = 1'b1;
        cpuPkg::OP_ADD: begin
          aluOp  = cpuPkg::ALU_ADD;
          flagWe = 1'b1;
        end
        cpuPkg::OP_SUB: begin
          aluOp  = cpuPkg::ALU_SUB;
          flagWe = 1'b1;
        end
        cpuPkg::OP_NAND: begin
          aluOp  = cpuPkg::ALU_NAND;
          flagWe = 1'b1;
        end
        cpuPkg::OP_BZ:  branchCond = zFlag;
        cpuPkg::OP_BNZ: branchCond = !zFlag;
        cpuPkg::OP_BPZ: branchCond = !nFlag;
        default:        branchCond = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (aluOp)
      cpuPkg::ALU_ADD:  aluOut = opAFwd + aluB;
      cpuPkg::ALU_SUB:  aluOut = opAFwd - aluB;
      cpuPkg::ALU_NAND: aluOut = ~(opAFwd & aluB);
      cpuPkg::ALU_OR:   aluOut = opAFwd | aluB;
      default:          aluOut = aluB;
    endcase
  end

  // A taken branch fetches its target in the same cycle, so only the
  // fetch and read stages need to be turned into bubbles
  assign taken     = execLive && branchCond;
  assign fetchAddr = taken ? execPc + 1'b1 + {{4{execInstr[7]}}, execInstr[7:4]} : pc;

  assign mem.instrAddr = fetchAddr;
  assign mem.dataAddr  = opBFwd;
  assign mem.dataWdata = opAFwd;
  assign mem.dataWe    = execLive && storeOp;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc <= '0;
      {fetchValid, readValid, execValid, wbValid} <= '0;
      {running, halted, nFlag, zFlag} <= '0;
    end else if (status.start) begin
      pc <= '0;
      {fetchValid, readValid, execValid, wbValid} <= '0;
      running <= 1'b1;
      halted  <= 1'b0;
    end else if (halting) begin
      {fetchValid, readValid, execValid, wbValid} <= '0;
      running <= 1'b0;
      halted  <= 1'b1;
    end else begin
      if (running) begin
        pc <= fetchAddr + 1'b1;
      end
      fetchValid <= running;
      readValid  <= fetchValid && !taken;
      execValid  <= readValid && !taken;
      wbValid    <= execLive;
      if (execLive && flagWe) begin
        nFlag <= aluOut[`CPU_DATA_WIDTH-1];
        zFlag <= aluOut == '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    fetchPc   <= fetchAddr;
    readInstr <= mem.instr;
    readPc    <= fetchPc;
    execInstr <= readInstr;
    execPc    <= readPc;
    // Read-through covers a writeback to the same register this cycle
    opA       <= (wbWrite && wbDest == regA(readInstr)) ? wbData : regs[regA(readInstr)];
    opB       <= (wbWrite && wbDest == readInstr[5:4]) ? wbData : regs[readInstr[5:4]];
    wbInstr   <= execInstr;
    wbData    <= aluOut;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (wbWrite) begin
      regs[wbDest] <= wbData;
    end
  end

  assign status.running = running;
  assign status.halted  = halted;
  assign status.retire  = wbValid;
  assign status.regs    = regs;

  assert property (@(posedge clock) disable iff (reset) halted |-> !status.retire)
    else $error("instruction retired after the core halted");

endmodule

`default_nettype wire

//--- design/perfMonitor.sv
/* Performance monitor
   Saturating cycle and retired-instruction counters, cleared on start */

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module perfMonitor (
  input  logic                        clock,
  input  logic                        reset,
  coreStatusIf.monitor                status,
  output logic [`CPU_COUNT_WIDTH-1:0] cycles,
  output logic [`CPU_COUNT_WIDTH-1:0] retired
);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cycles  <= '0;
      retired <= '0;
    end else if (status.start) begin
      cycles  <= '0;
      retired <= '0;
    end else begin
      // Both counters stick at all ones
      if (status.running && cycles != '1) begin
        cycles <= cycles + 1'b1;
      end
      if (status.retire && retired != '1) begin
        retired <= retired + 1'b1;
      end
    end
  end

  // Every retire happens in a running cycle, so retired cannot overtake cycles
  assert property (@(posedge clock) disable iff (reset) cycles >= retired)
    else $error("retired count exceeds cycle count");

endmodule

`default_nettype wire

//--- design/cpuTop.sv
/* CPU top level
   APB host port, pipeline core, unified memory and performance monitor */

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuTop (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [`CPU_APB_ADDR_WIDTH-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [`CPU_APB_DATA_WIDTH-1:0] pwdata,
  output logic [`CPU_APB_DATA_WIDTH-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr
);
  logic [`CPU_COUNT_WIDTH-1:0] cycles;
  logic [`CPU_COUNT_WIDTH-1:0] retired;

  memBusIf     memBus ();
  coreStatusIf coreStatus ();

  apbHostPort hostPort (
    .clock   (clock),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .mem     (memBus.host),
    .status  (coreStatus.host),
    .cycles  (cycles),
    .retired (retired)
  );

  unifiedMemory memory (
    .clock (clock),
    .bus   (memBus.mem)
  );

  pipelineCore core (
    .clock  (clock),
    .reset  (reset),
    .mem    (memBus.core),
    .status (coreStatus.core)
  );

  perfMonitor monitor (
    .clock   (clock),
    .reset   (reset),
    .status  (coreStatus.monitor),
    .cycles  (cycles),
    .retired (retired)
  );

endmodule

`default_nettype wire

//--- verif/cpuTb.sv
/* CPU testbench
   Loads table programs over APB, runs the pipelined core to halt and
   checks registers, memory, counters and host write protection */

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuTb;
  localparam int numTests   = 5;
  localparam int readyLimit = 8;
  localparam int pollLimit  = 300;

  localparam logic [3:0] opLoad  = 4'b0000;
  localparam logic [3:0] opStore = 4'b0010;
  localparam logic [3:0] opAdd   = 4'b0100;
  localparam logic [3:0] opBz    = 4'b0101;
  localparam logic [3:0] opSub   = 4'b0110;
  localparam logic [3:0] opNand  = 4'b1000;
  localparam logic [3:0] opBnz   = 4'b1001;
  localparam logic [3:0] opBpz   = 4'b1101;
  localparam logic [7:0] nopByte  = 8'h0A;
  localparam logic [7:0] stopByte = 8'h01;

  logic        clock;
  logic        reset;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  integer      seed;
  integer      testIndex;
  integer      k;
  logic [31:0] readValue;

  // Each row holds one program with its first instruction in the top byte
  // Expected registers are packed as {R3, R2, R1, R0}
  logic [127:0] progTable    [numTests];
  logic [31:0]  regTable     [numTests];
  logic [7:0]   initAddr     [numTests];
  logic [7:0]   initByte     [numTests];
  logic [7:0]   checkAddr    [numTests];
  logic [7:0]   checkByte    [numTests];
  logic [15:0]  retiredTable [numTests];
  logic         probeTable   [numTests];
  logic [7:0]   fillBytes    [32];

  cpuTop UUT (
    .clock   (clock),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [7:0] regInstr(input logic [3:0] op, input logic [1:0] rx,
                                          input logic [1:0] ry);
    return {rx, ry, op};
  endfunction

  function automatic logic [7:0] oriInstr(input logic [4:0] imm);
    return {imm, 3'b111};
  endfunction

  function automatic logic [7:0] branchInstr(input logic [3:0] op,
                                             input logic signed [3:0] offset);
    return {offset, op};
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
      else failRun($sformatf("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual));
  endtask

  task automatic checkTrue(input logic cond, input string what);
    assert (cond === 1'b1)
      else failRun(what);
  endtask

  // Setup phase, then access phase held until pready, sampled mid-cycle
  task automatic doTransfer(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output integer waits);
    integer count;
    logic done;
    @(posedge clock);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    count = 0;
    done  = 1'b0;
    while (!done) begin
      @(negedge clock);
      if (pready) begin
        done  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        count = count + 1;
        if (count > readyLimit) begin
          failRun($sformatf("pready never rose for the access to 0x%h", addr));
        end
      end
    end
    waits = count;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic hostWrite(input logic [11:0] addr, input logic [31:0] data,
                           input logic expErr);
    logic [31:0] rdata;
    logic err;
    integer waits;
    doTransfer(1'b1, addr, data, rdata, err, waits);
    checkValue($sformatf("pslverr on write to 0x%h", addr), expErr, err);
  endtask

  // Memory reads carry exactly one wait state and all other reads carry none
  task automatic hostRead(input logic [11:0] addr, output logic [31:0] data,
                          input logic expErr);
    logic [31:0] rdata;
    logic err;
    integer waits;
    doTransfer(1'b0, addr, 32'h0, rdata, err, waits);
    checkValue($sformatf("pslverr on read of 0x%h", addr), expErr, err);
    checkValue($sformatf("wait states on read of 0x%h", addr),
               (addr >= 12'h100 && addr <= 12'h1FF) ? 1 : 0, waits);
    data = rdata;
  endtask

  task automatic waitHalt();
    logic [31:0] value;
    integer polls;
    logic done;
    polls = 0;
    done  = 1'b0;
    while (!done) begin
      hostRead(`CPU_ADDR_STATUS, value, 1'b0);
      done  = value[0];
      polls = polls + 1;
      if (!done && polls >= pollLimit) begin
        failRun("core did not halt within the poll limit");
      end
    end
    checkValue("STATUS after halt", 32'h1, value);
  endtask

  task automatic buildTable();
    // Dependent ALU chain
    progTable[0] = {regInstr(opSub, 0, 0), regInstr(opSub, 1, 1), oriInstr(5'd5),
                    regInstr(opAdd, 0, 1), regInstr(opAdd, 0, 0), regInstr(opSub, 2, 2),
                    regInstr(opAdd, 2, 0), regInstr(opSub, 2, 1), regInstr(opSub, 3, 3),
                    regInstr(opNand, 3, 2), regInstr(opNand, 3, 0), oriInstr(5'h10),
                    stopByte, {3{nopByte}}};
    regTable[0] = {8'hF5, 8'h05, 8'h15, 8'h0A};
    {initAddr[0], initByte[0], checkAddr[0], checkByte[0]} = {8'h30, 8'h6E, 8'h0C, stopByte};
    retiredTable[0] = 16'd13;
    probeTable[0]   = 1'b0;
    // Load from host data, double it, store and load back
    progTable[1] = {regInstr(opSub, 1, 1), oriInstr(5'd29), regInstr(opSub, 0, 0),
                    regInstr(opLoad, 0, 1), regInstr(opAdd, 0, 0), regInstr(opSub, 2, 2),
                    regInstr(opAdd, 2, 1), regInstr(opAdd, 2, 2), regInstr(opStore, 0, 2),
                    regInstr(opSub, 3, 3), regInstr(opLoad, 3, 2), stopByte, {4{nopByte}}};
    regTable[1] = {8'h78, 8'h3A, 8'h1D, 8'h78};
    {initAddr[1], initByte[1], checkAddr[1], checkByte[1]} = {8'h1D, 8'h3C, 8'h3A, 8'h78};
    retiredTable[1] = 16'd12;
    probeTable[1]   = 1'b0;
    // Countdown loop summing 3+2+1, then taken and untaken BZ and BPZ
    progTable[2] = {regInstr(opSub, 0, 0), regInstr(opSub, 1, 1), regInstr(opNand, 2, 0),
                    oriInstr(5'd3), regInstr(opAdd, 0, 1), regInstr(opAdd, 1, 2),
                    branchInstr(opBnz, -3), branchInstr(opBz, 1), regInstr(opAdd, 0, 0),
                    branchInstr(opBpz, 1), regInstr(opAdd, 0, 0), regInstr(opNand, 3, 1),
                    branchInstr(opBpz, 1), branchInstr(opBz, 1), oriInstr(5'd2), stopByte};
    regTable[2] = {8'hFF, 8'hFF, 8'h02, 8'h06};
    {initAddr[2], initByte[2], checkAddr[2], checkByte[2]} = {8'h31, 8'h99, 8'h06, 8'hD9};
    retiredTable[2] = 16'd20;
    probeTable[2]   = 1'b0;
    // Long countdown from 31 while the host tries to write
    progTable[3] = {regInstr(opSub, 3, 3), regInstr(opSub, 0, 0), regInstr(opNand, 2, 0),
                    regInstr(opSub, 1, 1), oriInstr(5'd31), regInstr(opAdd, 1, 2),
                    branchInstr(opBnz, -2), stopByte, {8{nopByte}}};
    regTable[3] = {8'h00, 8'hFF, 8'h00, 8'h00};
    {initAddr[3], initByte[3], checkAddr[3], checkByte[3]} = {8'h40, 8'hA5, 8'h40, 8'hA5};
    retiredTable[3] = 16'd68;
    probeTable[3]   = 1'b1;
    // Short program after the long one where the NOP retires like any instruction
    progTable[4] = {regInstr(opSub, 0, 0), regInstr(opSub, 1, 1), oriInstr(5'd7), nopByte,
                    regInstr(opAdd, 0, 1), regInstr(opSub, 2, 2), regInstr(opSub, 3, 3),
                    stopByte, {8{nopByte}}};
    regTable[4] = {8'h00, 8'h00, 8'h07, 8'h07};
    {initAddr[4], initByte[4], checkAddr[4], checkByte[4]} = {8'h41, 8'h3F, 8'h41, 8'h3F};
    retiredTable[4] = 16'd8;
    probeTable[4]   = 1'b0;
  endtask

  task automatic runTest(input integer t);
    logic [31:0] value;
    logic [31:0] firstCycles;
    logic [31:0] secondCycles;
    logic [31:0] retiredCount;
    integer i;
    for (i = 0; i < 16; i = i + 1) begin
      hostWrite(`CPU_ADDR_MEM_BASE + i, progTable[t][127 - 8 * i -: 8], 1'b0);
    end
    hostWrite(`CPU_ADDR_MEM_BASE + initAddr[t], initByte[t], 1'b0);
    hostWrite(`CPU_ADDR_CTRL, 32'h1, 1'b0);
    if (probeTable[t]) begin
      hostRead(`CPU_ADDR_STATUS, value, 1'b0);
      checkValue("STATUS running bit", 32'h1, value[1]);
      hostWrite(`CPU_ADDR_MEM_BASE + initAddr[t], 32'h5A, 1'b1);
      hostWrite(`CPU_ADDR_CTRL, 32'h1, 1'b1);
    end
    waitHalt();
    for (i = 0; i < 4; i = i + 1) begin
      hostRead(`CPU_ADDR_REG_BASE + 4 * i, value, 1'b0);
      checkValue($sformatf("R%0d in test %0d", i, t), regTable[t][8 * i +: 8], value);
    end
    hostRead(`CPU_ADDR_MEM_BASE + checkAddr[t], value, 1'b0);
    checkValue($sformatf("mem[0x%h] in test %0d", checkAddr[t], t), checkByte[t], value);
    hostRead(`CPU_ADDR_RETIRED, retiredCount, 1'b0);
    checkValue($sformatf("RETIRED in test %0d", t), retiredTable[t], retiredCount);
    if (probeTable[t]) begin
      hostRead(`CPU_ADDR_CYCLES, firstCycles, 1'b0);
      hostRead(`CPU_ADDR_CYCLES, secondCycles, 1'b0);
      checkValue("CYCLES on second read", firstCycles, secondCycles);
      checkTrue(firstCycles != 0, "cycle counter stayed at zero after a run");
      checkTrue(firstCycles >= retiredCount, "cycle count is below the retired count");
    end
  endtask

  initial begin
    seed       = 32'h5b09cae0;
    reset      = 1'b1;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);
    checkValue("pready after reset", 32'h0, pready);
    checkValue("pslverr after reset", 32'h0, pslverr);
    hostRead(`CPU_ADDR_STATUS, readValue, 1'b0);
    checkValue("STATUS after reset", 32'h0, readValue);
    hostRead(`CPU_ADDR_CYCLES, readValue, 1'b0);
    checkValue("CYCLES after reset", 32'h0, readValue);
    hostRead(`CPU_ADDR_RETIRED, readValue, 1'b0);
    checkValue("RETIRED after reset", 32'h0, readValue);
    hostRead(12'h020, readValue, 1'b1);
    checkValue("unmapped read data", 32'h0, readValue);

    // Random bytes round trip through the host port
    for (k = 0; k < 32; k = k + 1) begin
      fillBytes[k] = $random(seed);
      hostWrite(`CPU_ADDR_MEM_BASE + 8'h80 + k, fillBytes[k], 1'b0);
    end
    for (k = 0; k < 32; k = k + 1) begin
      hostRead(`CPU_ADDR_MEM_BASE + 8'h80 + k, readValue, 1'b0);
      checkValue($sformatf("mem[0x%h]", 8'h80 + k), fillBytes[k], readValue);
    end

    buildTable();
    for (testIndex = 0; testIndex < numTests; testIndex = testIndex + 1) begin
      $display("Running program %0d", testIndex);
      runTest(testIndex);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/cpuPkg.sv
design/memBusIf.sv
design/coreStatusIf.sv
design/apbHostPort.sv
design/unifiedMemory.sv
design/pipelineCore.sv
design/perfMonitor.sv
design/cpuTop.sv
verif/cpuTb.sv

//--- Bender.yml
package:
  name: pipelined_cpu

sources:
  - include_dirs:
      - design
    files:
      - design/cpuPkg.sv
      - design/memBusIf.sv
      - design/coreStatusIf.sv
      - design/apbHostPort.sv
      - design/unifiedMemory.sv
      - design/pipelineCore.sv
      - design/perfMonitor.sv
      - design/cpuTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/cpuTb.sv
